// File: design/snd_pkg.sv
package snd_pkg;

    // board geometry
    localparam int NUM_VOICES = 2;
    localparam int ROM_AW     = 17;     // in-bank ROM address, bank bit sits above
    localparam int SMP_W      = 13;     // signed byte times 4-bit volume

    // mixer
    localparam int MIX_SHIFT  = 4;
    localparam int SAMPLE_DIV = 64;     // clk cycles per output sample
    localparam int BUF_DEPTH  = 2;      // per-voice buffer, also initial credits

    // derived widths
    localparam int CRED_W = $clog2(BUF_DEPTH + 1);
    localparam int PTR_W  = $clog2(BUF_DEPTH);
    localparam int DIV_W  = $clog2(SAMPLE_DIV);
    localparam int SUM_W  = SMP_W + NUM_VOICES + MIX_SHIFT;   // headroom for sum and shift

    // per-voice register offsets, host address bits 3:0
    localparam logic [3:0] REG_START0 = 4'd0;    // start address, low byte first
    localparam logic [3:0] REG_START1 = 4'd1;
    localparam logic [3:0] REG_START2 = 4'd2;
    localparam logic [3:0] REG_END0   = 4'd3;    // end address, low byte first
    localparam logic [3:0] REG_END1   = 4'd4;
    localparam logic [3:0] REG_END2   = 4'd5;
    localparam logic [3:0] REG_VOL    = 4'd6;
    localparam logic [3:0] REG_CTRL   = 4'd7;

    // control register bits
    localparam int CTRL_KEY  = 0;
    localparam int CTRL_LOOP = 1;

    // global bank latch, outside the voice map
    localparam logic [7:0] BANK_ADDR = 8'hf0;

    typedef struct packed {
        logic       wr;
        logic [7:0] addr;   // 7:4 voice, 3:0 register
        logic [7:0] data;
    } host_wr_t;

    typedef struct packed {
        logic [ROM_AW-1:0] start_addr;
        logic [ROM_AW-1:0] end_addr;    // inclusive
        logic [3:0]        vol;
        logic              loop;
    } voice_cfg_t;

endpackage

// File: design/snd_regs.sv
`timescale 1ns/1ps

module snd_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  snd_pkg::host_wr_t               host,
    output snd_pkg::voice_cfg_t             cfg [snd_pkg::NUM_VOICES],
    output logic [snd_pkg::NUM_VOICES-1:0]  key_on,
    output logic [snd_pkg::NUM_VOICES-1:0]  key_off,
    output logic                            bank
);

    logic [3:0] vsel;       // voice select
    logic [3:0] rsel;       // register select
    logic       vhit;       // write lands inside the voice map

    assign vsel = host.addr[7:4];
    assign rsel = host.addr[3:0];
    assign vhit = host.wr && (vsel < snd_pkg::NUM_VOICES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
                cfg[v] <= '0;
            end
            key_on  <= '0;
            key_off <= '0;
            bank    <= 1'b0;
        end else begin
            key_on  <= '0;      // pulses last one cycle
            key_off <= '0;
            for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
                if (vhit && vsel == 4'(v)) begin
                    case (rsel)
                        snd_pkg::REG_START0: cfg[v].start_addr[7:0]  <= host.data;
                        snd_pkg::REG_START1: cfg[v].start_addr[15:8] <= host.data;
                        snd_pkg::REG_START2: cfg[v].start_addr[16]   <= host.data[0];
                        snd_pkg::REG_END0:   cfg[v].end_addr[7:0]    <= host.data;
                        snd_pkg::REG_END1:   cfg[v].end_addr[15:8]   <= host.data;
                        snd_pkg::REG_END2:   cfg[v].end_addr[16]     <= host.data[0];
                        snd_pkg::REG_VOL:    cfg[v].vol              <= host.data[3:0];
                        snd_pkg::REG_CTRL: begin
                            cfg[v].loop <= host.data[snd_pkg::CTRL_LOOP];
                            key_on[v]   <= host.data[snd_pkg::CTRL_KEY];
                            key_off[v]  <= !host.data[snd_pkg::CTRL_KEY];
                        end
                        default: ;  // offsets 8..15 unused
                    endcase
                end
            end
            // bank bit drives ROM address bit 17 of every voice
            if (host.wr && host.addr == snd_pkg::BANK_ADDR) begin
                bank <= host.data[0];
            end
        end
    end

endmodule

// File: design/pcm_voice.sv
`timescale 1ns/1ps

module pcm_voice (
    input  logic                              clk,
    input  logic                              rst,
    input  snd_pkg::voice_cfg_t               cfg,
    input  logic                              key_on,
    input  logic                              key_off,
    input  logic                              bank,
    output logic                              rom_cs,
    output logic [snd_pkg::ROM_AW:0]          rom_addr,
    input  logic [7:0]                        rom_data,
    input  logic                              rom_ok,
    output logic                              push,
    output logic signed [snd_pkg::SMP_W-1:0]  smp,
    input  logic                              credit
);

    logic [snd_pkg::ROM_AW-1:0] addr;       // next byte to fetch
    logic [snd_pkg::ROM_AW:0]   req_addr;   // address of the fetch in flight
    logic                       active;
    logic                       pending;    // fetch issued, rom_ok not seen yet
    logic                       discard;    // fetch in flight belongs to a killed run
    logic [snd_pkg::CRED_W-1:0] credits;
    logic                       start;
    logic                       accept;
    logic                       kill;
    logic                       take;

    assign kill = key_on | key_off;

    // push in this cycle still holds a credit, so wait for it to be spent
    assign start  = active && !pending && !push && credits != '0;
    assign rom_cs = start || pending;
    assign rom_addr = pending ? req_addr : {bank, addr};

    assign accept = rom_cs && rom_ok;
    assign take   = accept && !discard && !kill;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr    <= '0;
            active  <= 1'b0;
            pending <= 1'b0;
            discard <= 1'b0;
            push    <= 1'b0;
            credits <= snd_pkg::CRED_W'(snd_pkg::BUF_DEPTH);
        end else begin
            pending <= rom_cs && !rom_ok;
            discard <= rom_cs && !rom_ok && (discard || kill);
            push    <= take;
            credits <= credits + snd_pkg::CRED_W'(credit) - snd_pkg::CRED_W'(push);

            if (key_on) begin
                addr   <= cfg.start_addr;
                active <= 1'b1;
            end else if (key_off) begin
                active <= 1'b0;     // in-flight fetch runs out and is dropped
            end else if (start) begin
                if (addr == cfg.end_addr) begin
                    if (cfg.loop) begin
                        addr <= cfg.start_addr;
                    end else begin
                        active <= 1'b0;
                    end
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= {bank, addr};
        end
        if (take) begin
            smp <= $signed(rom_data) * $signed({1'b0, cfg.vol});  // signed byte x unsigned vol
        end
    end

    // the mixer buffer has room for every push
    a_push_credit: assert property (
        @(posedge clk) disable iff (rst)
        push |-> credits != '0
    );

    // credits come back only for entries this voice pushed
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credits <= snd_pkg::CRED_W'(snd_pkg::BUF_DEPTH)
    );

endmodule

// File: design/snd_mixer.sv
`timescale 1ns/1ps

module snd_mixer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [snd_pkg::NUM_VOICES-1:0]    push,
    input  logic signed [snd_pkg::SMP_W-1:0]  smp [snd_pkg::NUM_VOICES],
    output logic [snd_pkg::NUM_VOICES-1:0]    credit,
    output logic signed [15:0]                snd,
    output logic                              sample,
    output logic                              peak
);

    logic [snd_pkg::DIV_W-1:0]        div_cnt;
    logic                             tick;
    logic signed [snd_pkg::SMP_W-1:0] buf_mem [snd_pkg::NUM_VOICES][snd_pkg::BUF_DEPTH];
    logic [snd_pkg::PTR_W-1:0]        wr_ptr [snd_pkg::NUM_VOICES];
    logic [snd_pkg::PTR_W-1:0]        rd_ptr [snd_pkg::NUM_VOICES];
    logic [snd_pkg::CRED_W-1:0]       count [snd_pkg::NUM_VOICES];
    logic [snd_pkg::NUM_VOICES-1:0]   pop;
    logic signed [snd_pkg::SUM_W-1:0] mix;

    function automatic logic [snd_pkg::PTR_W-1:0] ptr_inc(input logic [snd_pkg::PTR_W-1:0] p);
        if (p == snd_pkg::PTR_W'(snd_pkg::BUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign tick = div_cnt == snd_pkg::DIV_W'(snd_pkg::SAMPLE_DIV - 1);

    always_comb begin
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            pop[v] = tick && count[v] != '0;    // empty buffer sits this tick out
        end
    end

    // sum of buffer heads, then scaled up
    always_comb begin
        mix = '0;
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            if (pop[v]) begin
                mix = mix + buf_mem[v][rd_ptr[v]];
            end
        end
        mix = mix <<< snd_pkg::MIX_SHIFT;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
            credit <= '0;
        end else begin
            for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
                if (push[v]) begin
                    wr_ptr[v] <= ptr_inc(wr_ptr[v]);
                end
                if (pop[v]) begin
                    rd_ptr[v] <= ptr_inc(rd_ptr[v]);
                end
                count[v] <= count[v] + snd_pkg::CRED_W'(push[v]) - snd_pkg::CRED_W'(pop[v]);
            end
            credit <= pop;  // one credit back per popped entry
        end
    end

    always_ff @(posedge clk) begin
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            if (push[v]) begin
                buf_mem[v][wr_ptr[v]] <= smp[v];
            end
        end
    end

    // rate divider and saturating output stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sample  <= 1'b0;
            snd     <= '0;
            peak    <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            sample  <= tick;
            if (tick) begin
                if (mix > 32767) begin
                    snd  <= 16'sh7fff;
                    peak <= 1'b1;
                end else if (mix < -32768) begin
                    snd  <= -16'sh8000;
                    peak <= 1'b1;
                end else begin
                    snd  <= mix[15:0];
                    peak <= 1'b0;
                end
            end
        end
    end

    for (genvar v = 0; v < snd_pkg::NUM_VOICES; v++) begin : gen_chk
        // voice credit count must keep pushes away from a full buffer
        a_no_overflow: assert property (
            @(posedge clk) disable iff (rst)
            push[v] |-> count[v] != snd_pkg::CRED_W'(snd_pkg::BUF_DEPTH)
        );
    end

endmodule

// File: design/snd_top.sv
`timescale 1ns/1ps

module snd_top (
    input  logic                            clk,
    input  logic                            rst,
    input  snd_pkg::host_wr_t               host,
    output logic [snd_pkg::NUM_VOICES-1:0]  rom_cs,
    output logic [snd_pkg::ROM_AW:0]        rom_addr [snd_pkg::NUM_VOICES],
    input  logic [7:0]                      rom_data [snd_pkg::NUM_VOICES],
    input  logic [snd_pkg::NUM_VOICES-1:0]  rom_ok,
    output logic signed [15:0]              snd,
    output logic                            sample,
    output logic                            peak
);

    snd_pkg::voice_cfg_t              cfg [snd_pkg::NUM_VOICES];
    logic [snd_pkg::NUM_VOICES-1:0]   key_on;
    logic [snd_pkg::NUM_VOICES-1:0]   key_off;
    logic                             bank;     // ROM address bit 17, all voices
    logic [snd_pkg::NUM_VOICES-1:0]   push;
    logic [snd_pkg::NUM_VOICES-1:0]   credit;
    logic signed [snd_pkg::SMP_W-1:0] smp [snd_pkg::NUM_VOICES];

    snd_regs u_regs (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .host       ( host      ),
        .cfg        ( cfg       ),
        .key_on     ( key_on    ),
        .key_off    ( key_off   ),
        .bank       ( bank      )
    );

    for (genvar v = 0; v < snd_pkg::NUM_VOICES; v++) begin : gen_voice
        pcm_voice u_voice (
            .clk        ( clk           ),
            .rst        ( rst           ),
            .cfg        ( cfg[v]        ),
            .key_on     ( key_on[v]     ),
            .key_off    ( key_off[v]    ),
            .bank       ( bank          ),
            .rom_cs     ( rom_cs[v]     ),
            .rom_addr   ( rom_addr[v]   ),
            .rom_data   ( rom_data[v]   ),
            .rom_ok     ( rom_ok[v]     ),
            .push       ( push[v]       ),
            .smp        ( smp[v]        ),
            .credit     ( credit[v]     )
        );
    end

    // drains the voices once per sample period
    snd_mixer u_mixer (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .push       ( push      ),
        .smp        ( smp       ),
        .credit     ( credit    ),
        .snd        ( snd       ),
        .sample     ( sample    ),
        .peak       ( peak      )
    );

endmodule

// File: verif/snd_tb.sv
`timescale 1ns/1ps

module snd_tb;

    logic                                clk;
    logic                                rst;
    snd_pkg::host_wr_t                   host;
    logic [snd_pkg::NUM_VOICES-1:0]      rom_cs;
    logic [snd_pkg::ROM_AW:0]            rom_addr [snd_pkg::NUM_VOICES];
    logic [7:0]                          rom_data [snd_pkg::NUM_VOICES];
    logic [snd_pkg::NUM_VOICES-1:0]      rom_ok;
    logic signed [15:0]                  snd;
    logic                                sample;
    logic                                peak;

    int    seed = 32'hafe9;
    int    errors;
    int    checks;
    bit    loaded;
    byte   cmd_q [$];
    int    arg_a [$];
    int    arg_b [$];
    bit    busy [snd_pkg::NUM_VOICES];
    int    wait_cnt [snd_pkg::NUM_VOICES];
    logic [snd_pkg::ROM_AW:0] held_addr [snd_pkg::NUM_VOICES];  // address of the open fetch

    snd_top dut_i (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .host     ( host     ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .snd      ( snd      ),
        .sample   ( sample   ),
        .peak     ( peak     )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sample ROM contents: low address byte, voice pattern, bank flips the sign bit
    function automatic logic [7:0] rom_byte(input int v, input logic [snd_pkg::ROM_AW:0] a);
        logic [7:0] pat;
        pat = 8'(8'h55 * v);
        return a[7:0] ^ pat ^ (a[snd_pkg::ROM_AW] ? 8'h80 : 8'h00);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic host_write(input int a, input int d);
        host.wr   = 1'b1;
        host.addr = 8'(a);
        host.data = 8'(d);
        @(posedge clk);
        #1;
        host.wr = 1'b0;
    endtask

    task automatic next_sample();
        do begin
            @(posedge clk);
            #1;
        end while (!sample);
    endtask

    task automatic load_vectors();
        int    fd;
        int    a;
        int    b;
        string line;
        fd = $fopen("verif/snd_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the vector file verif/snd_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 1 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                    continue;
                end
                a = 0;
                b = 0;
                if (line.len() > 2) begin
                    void'($sscanf(line.substr(2, line.len() - 1), "%h %h", a, b));
                end
                cmd_q.push_back(line.getc(0));
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
            $fclose(fd);
        end
    endtask

    // ROM models, latency 1 to 4 cycles per fetch
    initial begin
        rom_ok = '0;
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            rom_data[v]  = 8'h00;
            busy[v]      = 1'b0;
            wait_cnt[v]  = 0;
            held_addr[v] = '0;
        end
        forever begin
            @(posedge clk);
            #1;
            for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
                if (rom_ok[v]) begin
                    rom_ok[v] = 1'b0;   // accepted last cycle
                    busy[v]   = 1'b0;
                end
                if (busy[v]) begin
                    // request stays put until rom_ok
                    check("rom_cs", {31'h0, rom_cs[v]}, 32'h1);
                    check("rom_addr", 32'(rom_addr[v]), 32'(held_addr[v]));
                    if (wait_cnt[v] != 0) wait_cnt[v]--;
                end else if (rom_cs[v] && !rst) begin
                    busy[v]      = 1'b1;
                    held_addr[v] = rom_addr[v];
                    wait_cnt[v]  = $random(seed) & 3;
                end
                if (busy[v] && wait_cnt[v] == 0) begin
                    rom_ok[v]   = 1'b1;
                    rom_data[v] = rom_byte(v, rom_addr[v]);
                end
            end
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (cmd_q.size() + 1) * snd_pkg::SAMPLE_DIV * 8;
        repeat (limit) @(posedge clk);
        $display("timeout: the vector run did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        errors    = 0;
        checks    = 0;
        loaded    = 1'b0;
        rst       = 1'b1;
        host.wr   = 1'b0;
        host.addr = 8'h00;
        host.data = 8'h00;
        load_vectors();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check("snd", {16'h0, snd}, 32'h0);
        check("peak", {31'h0, peak}, 32'h0);
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "W": host_write(arg_a[i], arg_b[i]);
                "P": next_sample();
                "E": begin
                    next_sample();
                    check("snd", {16'h0, snd}, {16'h0, arg_a[i][15:0]});
                    check("peak", {31'h0, peak}, {31'h0, arg_b[i][0]});
                end
                default: begin
                    errors++;
                    $display("unknown command in vector line %0d", i);
                end
            endcase
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verif/snd_vectors.txt
# W addr data = host write, P = wait for sample, E snd peak = wait and compare
# all values hex
E 0 0
E 0 0
W 00 10
W 03 12
W 06 0f
P
W 07 01
E 0f00 0
E 0ff0 0
E 10e0 0
E 0 0
W 00 20
W 03 21
W 06 04
P
W 07 03
E 0800 0
E 0840 0
E 0800 0
E 0840 0
W 07 00
E 0800 0
E 0 0
W 00 30
W 03 31
W 06 02
W 10 30
W 13 31
W 16 03
P
W 07 01
W 17 01
E 18f0 0
E 18e0 0
E 0 0
W 00 7f
W 03 80
W 06 0f
W 10 7f
W 13 81
W 16 0f
P
W 07 01
W 17 01
E 7fff 1
E 8000 1
E d6c0 0
E 0 0
W 00 05
W 03 06
W 06 01
P
W 07 01
E 0050 0
E 0060 0
E 0 0
W f0 01
P
W 07 01
E f850 0
E f860 0
E 0 0

// File: vlog.f
design/snd_pkg.sv
design/snd_regs.sv
design/pcm_voice.sv
design/snd_mixer.sv
design/snd_top.sv
verif/snd_tb.sv

// File: run.sh
#!/bin/bash
# build and run the sound board testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module snd_tb -f vlog.f -o snd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
